// ==== compile.f ====
+incdir+include
src/pdp8_pkg.sv
src/instr_decode.sv
src/cpu_sequencer.sv
src/acc_unit.sv
src/addr_unit.sv
src/pdp8_core.sv
testbench/tb_pdp8.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_pdp8 -Mdir obj_dir \
  && ./obj_dir/Vtb_pdp8 > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0

// ==== src/acc_unit.sv ====
// Accumulator, link and memory buffer with the memory write-data register
`timescale 1ns/1ps

module acc_unit import pdp8_pkg::*; (
  input  logic              clock,
  input  logic              resetN,
  input  logic [2:0]        ac_op,
  input  logic [1:0]        mb_op,
  input  logic [1:0]        wd_sel,
  input  logic [word_w-1:0] mem_rdata,
  input  logic [word_w-1:0] pc,
  input  logic              g1_cla,
  input  logic              g1_cll,
  input  logic              g1_cma,
  input  logic              g1_cml,
  input  logic              g1_iac,
  output logic [word_w-1:0] ac,
  output logic              link,
  output logic              mb_zero,
  output logic [word_w-1:0] mem_wdata
);

  logic [word_w-1:0] mb;
  logic [word_w:0]   tad_sum;
  logic [word_w:0]   g1_sum;
  logic [word_w-1:0] g1_ac;
  logic              g1_link;

  assign tad_sum = {1'b0, ac} + {1'b0, mb};
  assign mb_zero = (mb == '0);

  // Group 1 in order CLA, CLL, CMA, CML, IAC
  always_comb begin
    g1_ac   = g1_cla ? '0 : ac;
    g1_link = g1_cll ? 1'b0 : link;
    g1_ac   = g1_cma ? ~g1_ac : g1_ac;
    g1_link = g1_cml ? ~g1_link : g1_link;
    g1_sum  = {1'b0, g1_ac} + g1_iac;
    g1_ac   = g1_sum[word_w-1:0];
    g1_link = g1_link ^ g1_sum[word_w];   // Carry out flips the link
  end

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      ac   <= '0;
      link <= 1'b0;
    end else begin
      case (ac_op)
        ac_and:       ac <= ac & mb;
        ac_tad: begin
          ac   <= tad_sum[word_w-1:0];
          link <= link ^ tad_sum[word_w];
        end
        ac_dca_clear: ac <= '0;
        ac_group1: begin
          ac   <= g1_ac;
          link <= g1_link;
        end
        ac_clear_all: begin
          ac   <= '0;
          link <= 1'b0;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ac_op == ac_clear_all)
      mb <= '0;
    else if (mb_op == mb_load)
      mb <= mem_rdata;
    else if (mb_op == mb_inc)
      mb <= mb + 1'b1;              // ISZ
  end

  always_ff @(posedge clock) begin
    case (wd_sel)
      wd_mb:   mem_wdata <= mb;
      wd_pc:   mem_wdata <= pc;
      default: mem_wdata <= ac;
    endcase
  end

endmodule

// ==== src/addr_unit.sv ====
// Program counter, effective address and the memory address register
`timescale 1ns/1ps

module addr_unit import pdp8_pkg::*; (
  input  logic              clock,
  input  logic              resetN,
  input  logic [2:0]        pc_op,
  input  logic [1:0]        ea_op,
  input  logic              ad_sel,
  input  logic              current_page,
  input  logic [6:0]        page_offset,
  input  logic [word_w-1:0] mem_rdata,
  input  logic [word_w-1:0] switch_reg,
  output logic [word_w-1:0] pc,
  output logic [word_w-1:0] mem_address
);

  localparam int off_w = $bits(page_offset);

  logic [word_w-1:0] ea;
  logic [word_w-1:0] ea_direct_addr;

  // Current page uses the PC after the fetch increment
  assign ea_direct_addr = current_page ? {pc[word_w-1:off_w], page_offset}
                                       : word_w'(page_offset);

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN)
      pc <= '0;
    else begin
      case (pc_op)
        pc_inc:    pc <= pc + 1'b1;
        pc_sr:     pc <= switch_reg;
        pc_ea:     pc <= ea;
        pc_ea_inc: pc <= ea + 1'b1;   // JMS return slot skipped
        pc_clear:  pc <= '0;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ea_op == ea_direct)
      ea <= ea_direct_addr;
    else if (ea_op == ea_indirect)
      ea <= mem_rdata;            // One level of indirection
  end

  // Held stable through each strobe
  always_ff @(posedge clock) begin
    mem_address <= (ad_sel == ad_ea) ? ea : pc;
  end

endmodule

// ==== src/cpu_sequencer.sv ====
// Control FSM for init, panel load, fetch, addressing, execute and halt
`timescale 1ns/1ps

module cpu_sequencer import pdp8_pkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  logic       run,
  input  logic       step,
  input  logic       loadpc,
  input  logic       mem_finished,
  input  logic [2:0] opcode,
  input  logic       indirect,
  input  logic       is_halt,
  input  logic       mb_zero,
  output logic       load_ir,
  output logic [2:0] ac_op,
  output logic [1:0] mb_op,
  output logic [1:0] wd_sel,
  output logic [2:0] pc_op,
  output logic [1:0] ea_op,
  output logic       ad_sel,
  output logic       mem_read,
  output logic       mem_write,
  output logic       cpu_idle,
  output logic       halt
);

  localparam logic [4:0]
    st_reset      = 5'd0,
    st_init       = 5'd1,
    st_idle       = 5'd2,
    st_ldpc       = 5'd3,
    st_fetch_addr = 5'd4,
    st_fetch_read = 5'd5,
    st_decode     = 5'd6,
    st_ea_calc    = 5'd7,
    st_ind_addr   = 5'd8,
    st_ind_read   = 5'd9,
    st_rd_addr    = 5'd10,
    st_rd_wait    = 5'd11,
    st_wr_addr    = 5'd12,
    st_wr_wait    = 5'd13,
    st_and_exec   = 5'd14,
    st_tad_exec   = 5'd15,
    st_isz_inc    = 5'd16,
    st_isz_skip   = 5'd17,
    st_dca_clear  = 5'd18,
    st_jms_jump   = 5'd19,
    st_jmp_exec   = 5'd20,
    st_opr_exec   = 5'd21,
    st_halt       = 5'd22;

  logic [4:0] state;
  logic [4:0] next_state;
  logic [4:0] ea_target;
  logic [1:0] wr_data;

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN)
      state <= st_reset;
    else
      state <= next_state;
  end

  // First state once the effective address is known
  always_comb begin
    case (opcode)
      op_and, op_tad, op_isz: ea_target = st_rd_addr;
      op_dca, op_jms:         ea_target = st_wr_addr;
      default:                ea_target = st_jmp_exec;
    endcase
  end

  assign wr_data = (opcode == op_dca) ? wd_ac : (opcode == op_jms) ? wd_pc : wd_mb;

  always_comb begin
    next_state = state;
    case (state)
      st_reset:      next_state = st_init;
      st_init:       next_state = st_idle;
      st_idle: begin
        if (run || step)
          next_state = st_fetch_addr;
        else if (loadpc)
          next_state = st_ldpc;
      end
      st_fetch_addr: next_state = st_fetch_read;
      st_fetch_read: if (mem_finished) next_state = st_decode;
      st_decode: begin
        if (is_halt)
          next_state = st_halt;
        else if (opcode == op_opr)
          next_state = st_opr_exec;
        else if (opcode == op_iot)
          next_state = st_idle;          // IOT is a no-op
        else
          next_state = st_ea_calc;
      end
      st_ea_calc:    next_state = indirect ? st_ind_addr : ea_target;
      st_ind_addr:   next_state = st_ind_read;
      st_ind_read:   if (mem_finished) next_state = ea_target;
      st_rd_addr:    next_state = st_rd_wait;
      st_rd_wait: begin
        if (mem_finished)
          next_state = (opcode == op_and) ? st_and_exec :
                       (opcode == op_tad) ? st_tad_exec : st_isz_inc;
      end
      st_isz_inc:    next_state = st_wr_addr;
      st_wr_addr:    next_state = st_wr_wait;
      st_wr_wait: begin
        if (mem_finished)
          next_state = (opcode == op_isz) ? st_isz_skip :
                       (opcode == op_dca) ? st_dca_clear : st_jms_jump;
      end
      st_halt:       if (!run) next_state = st_idle;
      default:       next_state = st_idle;   // Last cycle of an instruction
    endcase
  end

  always_comb begin
    load_ir   = 1'b0;
    ac_op     = ac_nc;
    mb_op     = mb_nc;
    wd_sel    = wd_ac;
    pc_op     = pc_nc;
    ea_op     = ea_nc;
    ad_sel    = ad_pc;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    cpu_idle  = 1'b0;
    halt      = 1'b0;
    case (state)
      st_init: begin
        ac_op = ac_clear_all;
        ea_op = ea_direct;              // IR is zero here, so EA clears
        pc_op = pc_clear;
      end
      st_idle:       cpu_idle = 1'b1;
      st_ldpc:       pc_op = pc_sr;
      st_fetch_read: begin
        mem_read = 1'b1;
        if (mem_finished) begin
          load_ir = 1'b1;
          pc_op   = pc_inc;
        end
      end
      st_ea_calc:    ea_op = ea_direct;
      st_ind_addr:   ad_sel = ad_ea;
      st_ind_read: begin
        ad_sel   = ad_ea;
        mem_read = 1'b1;
        if (mem_finished)
          ea_op = ea_indirect;
      end
      st_rd_addr:    ad_sel = ad_ea;
      st_rd_wait: begin
        ad_sel   = ad_ea;
        mem_read = 1'b1;
        if (mem_finished)
          mb_op = mb_load;
      end
      st_wr_addr: begin
        ad_sel = ad_ea;
        wd_sel = wr_data;
      end
      st_wr_wait: begin
        ad_sel    = ad_ea;
        wd_sel    = wr_data;
        mem_write = 1'b1;
      end
      st_and_exec:   ac_op = ac_and;
      st_tad_exec:   ac_op = ac_tad;
      st_isz_inc:    mb_op = mb_inc;
      st_isz_skip:   if (mb_zero) pc_op = pc_inc;
      st_dca_clear:  ac_op = ac_dca_clear;
      st_jms_jump:   pc_op = pc_ea_inc;
      st_jmp_exec:   pc_op = pc_ea;
      st_opr_exec:   ac_op = ac_group1;
      st_halt:       halt = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== src/instr_decode.sv ====
// Instruction register with memory-reference and group-1 operate decode
`timescale 1ns/1ps

module instr_decode import pdp8_pkg::*; (
  input  logic              clock,
  input  logic              resetN,
  input  logic              load_ir,
  input  logic [word_w-1:0] mem_rdata,
  output logic [2:0]        opcode,
  output logic              indirect,
  output logic              current_page,
  output logic [6:0]        page_offset,
  output logic              is_halt,
  output logic              g1_cla,
  output logic              g1_cll,
  output logic              g1_cma,
  output logic              g1_cml,
  output logic              g1_iac
);

  instr_word_t ir;
  logic        is_group1;

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN)
      ir <= '0;               // Zero offset lets init clear EA
    else if (load_ir)
      ir <= mem_rdata;
  end

  assign opcode       = ir.mem_ref.opcode;
  assign indirect     = ir.mem_ref.indirect;
  assign current_page = ir.mem_ref.current_page;
  assign page_offset  = ir.mem_ref.page_offset;

  assign is_group1 = (ir.operate.opcode == op_opr) && !ir.operate.group;
  assign is_halt   = (ir == halt_word);

  // Group 2 and 3 words leave these low and run as no-ops
  assign g1_cla = is_group1 & ir.operate.cla;
  assign g1_cll = is_group1 & ir.operate.cll;
  assign g1_cma = is_group1 & ir.operate.cma;
  assign g1_cml = is_group1 & ir.operate.cml;
  assign g1_iac = is_group1 & ir.operate.iac;

endmodule

// ==== src/pdp8_core.sv ====
// Processor top level: decode, sequencer, accumulator and address units
`timescale 1ns/1ps

module pdp8_core import pdp8_pkg::*; (
  input  logic              clock,
  input  logic              resetN,
  input  logic              run,
  input  logic              step,
  input  logic              loadpc,
  input  logic [word_w-1:0] switch_reg,
  input  logic [word_w-1:0] mem_rdata,
  input  logic              mem_finished,
  output logic [word_w-1:0] mem_address,
  output logic [word_w-1:0] mem_wdata,
  output logic              mem_read,
  output logic              mem_write,
  output logic [word_w-1:0] ac,
  output logic              link,
  output logic [word_w-1:0] pc,
  output logic              cpu_idle,
  output logic              halt
);

  logic [2:0] opcode;
  logic       indirect;
  logic       current_page;
  logic [6:0] page_offset;
  logic       is_halt;
  logic       g1_cla;
  logic       g1_cll;
  logic       g1_cma;
  logic       g1_cml;
  logic       g1_iac;
  logic       mb_zero;
  logic       load_ir;
  logic [2:0] ac_op;
  logic [1:0] mb_op;
  logic [1:0] wd_sel;
  logic [2:0] pc_op;
  logic [1:0] ea_op;
  logic       ad_sel;

  instr_decode decode0 (
    .clock, .resetN, .load_ir, .mem_rdata,
    .opcode, .indirect, .current_page, .page_offset, .is_halt,
    .g1_cla, .g1_cll, .g1_cma, .g1_cml, .g1_iac
  );

  cpu_sequencer seq0 (
    .clock, .resetN, .run, .step, .loadpc, .mem_finished,
    .opcode, .indirect, .is_halt, .mb_zero,
    .load_ir, .ac_op, .mb_op, .wd_sel, .pc_op, .ea_op, .ad_sel,
    .mem_read, .mem_write, .cpu_idle, .halt
  );

  acc_unit acc0 (
    .clock, .resetN, .ac_op, .mb_op, .wd_sel, .mem_rdata, .pc,
    .g1_cla, .g1_cll, .g1_cma, .g1_cml, .g1_iac,
    .ac, .link, .mb_zero, .mem_wdata
  );

  addr_unit addr0 (
    .clock, .resetN, .pc_op, .ea_op, .ad_sel, .current_page, .page_offset,
    .mem_rdata, .switch_reg, .pc, .mem_address
  );

endmodule

// ==== src/pdp8_pkg.sv ====
// Word width, two-view instruction word, opcodes and datapath control codes
package pdp8_pkg;

  localparam int word_w = 12;

  // One instruction word, read either as a memory reference or as an operate
  typedef union packed {
    struct packed {
      logic [2:0] opcode;
      logic       indirect;
      logic       current_page;
      logic [6:0] page_offset;
    } mem_ref;
    struct packed {
      logic [2:0] opcode;
      logic       group;      // 0 selects group 1
      logic       cla;
      logic       cll;
      logic       cma;
      logic       cml;
      logic       rar;
      logic       ral;
      logic       bsw;
      logic       iac;
    } operate;
  } instr_word_t;

  localparam logic [2:0] op_and = 3'o0;
  localparam logic [2:0] op_tad = 3'o1;
  localparam logic [2:0] op_isz = 3'o2;
  localparam logic [2:0] op_dca = 3'o3;
  localparam logic [2:0] op_jms = 3'o4;
  localparam logic [2:0] op_jmp = 3'o5;
  localparam logic [2:0] op_iot = 3'o6;
  localparam logic [2:0] op_opr = 3'o7;

  localparam logic [word_w-1:0] halt_word = 12'o7402;

  localparam logic [2:0] ac_nc        = 3'd0;
  localparam logic [2:0] ac_and       = 3'd1;
  localparam logic [2:0] ac_tad       = 3'd2;
  localparam logic [2:0] ac_dca_clear = 3'd3;
  localparam logic [2:0] ac_group1    = 3'd4;
  localparam logic [2:0] ac_clear_all = 3'd5; // AC, link and MB

  localparam logic [1:0] mb_nc   = 2'd0;
  localparam logic [1:0] mb_load = 2'd1;
  localparam logic [1:0] mb_inc  = 2'd2;

  localparam logic [1:0] wd_ac = 2'd0;
  localparam logic [1:0] wd_mb = 2'd1;
  localparam logic [1:0] wd_pc = 2'd2;

  localparam logic [2:0] pc_nc     = 3'd0;
  localparam logic [2:0] pc_inc    = 3'd1;
  localparam logic [2:0] pc_sr     = 3'd2;
  localparam logic [2:0] pc_ea     = 3'd3;
  localparam logic [2:0] pc_ea_inc = 3'd4;
  localparam logic [2:0] pc_clear  = 3'd5;

  localparam logic [1:0] ea_nc       = 2'd0;
  localparam logic [1:0] ea_direct   = 2'd1;
  localparam logic [1:0] ea_indirect = 2'd2;

  localparam logic ad_pc = 1'b0;
  localparam logic ad_ea = 1'b1;

endpackage

// ==== include/pdp8_ref_model.svh ====
// Reference model for the testbench
// Model memory and registers, and one-instruction execution
`ifndef PDP8_REF_MODEL_SVH
`define PDP8_REF_MODEL_SVH

logic [word_w-1:0] model_mem [0:(1 << word_w) - 1];
logic [word_w-1:0] model_ac;
logic              model_link;
logic [word_w-1:0] model_pc;

// Runs the word at model_pc, returns 1 for HALT
function automatic bit model_step();
  instr_word_t       ir;
  logic [word_w-1:0] ea;
  logic [word_w:0]   sum;
  ir       = model_mem[model_pc];
  model_pc = model_pc + 1'b1;
  if (ir == halt_word)
    return 1'b1;
  ea = ir.mem_ref.current_page ? {model_pc[word_w-1:7], ir.mem_ref.page_offset}
                               : word_w'(ir.mem_ref.page_offset);
  if (ir.mem_ref.indirect && ir.mem_ref.opcode < op_iot)
    ea = model_mem[ea];
  case (ir.mem_ref.opcode)
    op_and: model_ac = model_ac & model_mem[ea];
    op_tad: begin
      sum        = {1'b0, model_ac} + {1'b0, model_mem[ea]};
      model_ac   = sum[word_w-1:0];
      model_link = model_link ^ sum[word_w];
    end
    op_isz: begin
      model_mem[ea] = model_mem[ea] + 1'b1;
      if (model_mem[ea] == '0)
        model_pc = model_pc + 1'b1;
    end
    op_dca: begin
      model_mem[ea] = model_ac;
      model_ac      = '0;
    end
    op_jms: begin
      model_mem[ea] = model_pc;
      model_pc      = ea + 1'b1;
    end
    op_jmp: model_pc = ea;
    op_opr: begin
      if (!ir.operate.group) begin
        if (ir.operate.cla) model_ac = '0;
        if (ir.operate.cll) model_link = 1'b0;
        if (ir.operate.cma) model_ac = ~model_ac;
        if (ir.operate.cml) model_link = ~model_link;
        if (ir.operate.iac) begin
          sum        = {1'b0, model_ac} + 1'b1;
          model_ac   = sum[word_w-1:0];
          model_link = model_link ^ sum[word_w];
        end
      end
    end
    default: ;                      // IOT is a no-op
  endcase
  return 1'b0;
endfunction

`endif

// ==== testbench/tb_pdp8.sv ====
// Testbench for pdp8_core with memory responder, panel, step and run tests
// Results are compared with the reference model in pdp8_ref_model.svh
`timescale 1ns/1ps

module tb_pdp8 import pdp8_pkg::*; ();

  localparam int cycles_per_instr = 20;
  localparam int program_len      = 64;
  localparam int n_programs       = 20;
  localparam int n_steps          = 40;
  localparam int cycle_limit = cycles_per_instr * (program_len * n_programs + 2 * n_steps + 8);

  logic              clock        = 1'b0;
  logic              resetN       = 1'b0;
  logic              run          = 1'b0;
  logic              step         = 1'b0;
  logic              loadpc       = 1'b0;
  logic [word_w-1:0] switch_reg   = '0;
  logic [word_w-1:0] mem_rdata    = '0;
  logic              mem_finished = 1'b0;
  logic [word_w-1:0] mem_address;
  logic [word_w-1:0] mem_wdata;
  logic              mem_read;
  logic              mem_write;
  logic [word_w-1:0] ac;
  logic              link;
  logic [word_w-1:0] pc;
  logic              cpu_idle;
  logic              halt;

  logic [word_w-1:0] tb_mem [0:(1 << word_w) - 1];
  logic [31:0]       rng_state    = 32'h7d65_22a7;
  logic              mem_busy     = 1'b0;
  int                mem_delay    = 0;
  int                cycle_count  = 0;
  int                check_errors = 0;
  int                test_errors  = 0;
  int                tests_run    = 0;
  int                tests_failed = 0;

  `include "pdp8_ref_model.svh"

  pdp8_core dut0 (.*);

  always #50 clock = ~clock;

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Answers each strobe 1 to 4 clocks after it rises
  always @(negedge clock) begin
    mem_finished <= 1'b0;
    if (resetN && !mem_finished && (mem_read || mem_write)) begin
      if (!mem_busy) begin
        mem_busy  = 1'b1;
        mem_delay = int'(next_random() % 4);
      end
      if (mem_delay == 0) begin
        if (mem_write)
          tb_mem[mem_address] = mem_wdata;
        else
          mem_rdata <= tb_mem[mem_address];
        mem_finished <= 1'b1;
        mem_busy = 1'b0;
      end else
        mem_delay--;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: no result after %0d clock cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0d ns: %s expected %0o, got %0o",
               $time, name, expected, actual);
      check_errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0)
      $display("test %-10s ok", name);
    else begin
      tests_failed++;
      $display("test %-10s %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic put_word(input logic [word_w-1:0] addr, input logic [word_w-1:0] w);
    tb_mem[addr]    = w;
    model_mem[addr] = w;
  endtask

  task automatic fill_memory(input logic [word_w-1:0] salt);
    for (int a = 0; a < (1 << word_w); a++)
      put_word(word_w'(a), word_w'(a * 37) ^ salt);  // 37 is odd, so every address differs
  endtask

  task automatic check_registers();
    check_value("ac", model_ac, ac);
    check_value("link", model_link, link);
    check_value("pc", model_pc, pc);
  endtask

  task automatic compare_memory();
    for (int a = 0; a < (1 << word_w); a++)
      if (tb_mem[a] !== model_mem[a])
        check_value($sformatf("mem[%04o]", a), model_mem[a], tb_mem[a]);
  endtask

  task automatic wait_for_idle();
    while (!cpu_idle)
      @(negedge clock);
  endtask

  task automatic load_pc(input logic [word_w-1:0] value);
    switch_reg = value;
    loadpc     = 1'b1;
    @(negedge clock);
    loadpc = 1'b0;
    wait_for_idle();
    model_pc = value;
  endtask

  // Places the word at the current PC, then runs it on both model and DUT
  task automatic step_instr(input logic [word_w-1:0] w);
    put_word(model_pc, w);
    void'(model_step());
    step = 1'b1;
    @(negedge clock);
    step = 1'b0;
    wait_for_idle();
  endtask

  function automatic logic [word_w-1:0] group1_word(input logic [4:0] b);
    return {op_opr, 1'b0, b[3:0], 3'b000, b[4]};    // Rotate and swap bits clear
  endfunction

  function automatic logic [word_w-1:0] basic_word(input logic [31:0] r);
    case (r[1:0])
      2'd0:    return {op_and, 1'b0, r[9], r[8:2]};
      2'd1:    return {op_tad, 1'b0, r[9], r[8:2]};
      2'd2:    return {op_dca, 1'b0, r[9], r[8:2]};
      default: return group1_word(r[14:10]);
    endcase
  endfunction

  task automatic flow_step();
    logic [31:0]       r;
    logic [word_w-1:0] w;
    logic [word_w-1:0] next_pc;
    logic [word_w-1:0] ea;
    r = next_random();
    case (r[1:0])
      2'd1:    w = {op_jmp, r[2], r[3], r[10:4]};
      2'd2:    w = {op_jms, r[2], r[3], r[10:4]};
      default: w = {op_isz, r[2], r[3], r[10:4]};
    endcase
    next_pc = model_pc + 12'd1;
    ea = w[7] ? {next_pc[word_w-1:7], w[6:0]} : {5'd0, w[6:0]};
    // Direct ISZ now and then gets a counter about to wrap
    if (w[11:9] == op_isz && !w[8] && r[20] && ea != model_pc)
      put_word(ea, 12'o7777);
    step_instr(w);
    check_value("pc", model_pc, pc);
    compare_memory();
  endtask

  task automatic run_program();
    logic [31:0]       r;
    logic [word_w-1:0] start;
    logic [word_w-1:0] w;
    int                len;
    int                target;
    bit                halted;
    r = next_random();
    fill_memory(r[11:0]);
    r = next_random();
    start = {5'(1 + r[15:0] % 31), 1'b0, r[21:16]};  // Whole program fits in one page
    len   = 8 + int'(r[31:24] % 55);
    for (int i = 0; i < len; i++) begin
      r = next_random();
      case (r[2:0])
        3'd0: w = {op_and, 2'b00, r[9:3]};
        3'd1: w = {op_tad, 2'b00, r[9:3]};
        3'd2: w = {op_isz, 2'b00, r[9:3]};
        3'd3: w = {op_dca, 2'b00, r[9:3]};
        3'd4: w = group1_word(r[12:8]);
        3'd5: begin
          target = i + 1 + int'(r[15:8] % (len - i));  // Forward only
          w = {op_jmp, 2'b01, 7'(int'(start[6:0]) + target)};
        end
        3'd6: w = {op_iot, r[11:3]};
        default: w = {op_opr, 1'b1, r[10:4], 1'b1};  // Group 3 no-op
      endcase
      put_word(start + word_w'(i), w);
    end
    put_word(start + word_w'(len), halt_word);
    put_word(start + word_w'(len + 1), halt_word);  // Catches a skip over the last word
    load_pc(start);
    halted = 1'b0;
    for (int k = 0; k < 2 * program_len && !halted; k++)
      halted = model_step();
    run = 1'b1;
    @(negedge clock);
    while (!halt)
      @(negedge clock);
    check_registers();
    compare_memory();
    run = 1'b0;
    @(negedge clock);
    wait_for_idle();
    check_value("halt", 0, halt);
  endtask

  initial begin : main
    logic [31:0] r;
    model_ac   = '0;
    model_link = 1'b0;
    model_pc   = '0;
    repeat (8) @(negedge clock);
    check_value("cpu_idle", 0, cpu_idle);   // Still in reset
    check_value("halt", 0, halt);
    check_value("mem_read", 0, mem_read);
    check_value("mem_write", 0, mem_write);
    resetN = 1'b1;
    @(negedge clock);
    check_value("cpu_idle", 0, cpu_idle);   // Init state
    @(negedge clock);
    check_value("cpu_idle", 1, cpu_idle);
    check_value("halt", 0, halt);
    check_value("ac", 0, ac);
    check_value("link", 0, link);
    check_value("pc", 0, pc);
    finish_test("reset");

    repeat (4) begin
      r = next_random();
      load_pc(r[11:0]);
      check_value("pc", r[11:0], pc);
    end
    finish_test("loadpc");

    r = next_random();
    fill_memory(r[11:0]);
    for (int i = 0; i < n_steps; i++) begin
      step_instr(basic_word(next_random()));
      check_registers();
    end
    finish_test("step_alu");

    for (int i = 0; i < n_steps; i++)
      flow_step();
    finish_test("step_flow");

    for (int p = 0; p < n_programs; p++)
      run_program();
    finish_test("run");

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             check_errors);
    if (tests_failed == 0 && check_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
